/* hdl/addr_gen_consts.svh */
`ifndef ADDR_GEN_CONSTS_SVH
`define ADDR_GEN_CONSTS_SVH

// Databus side widths
`define AG_AXI_ADDR_W 32
`define AG_LEN_W 8
`define AG_COUNT_W 8

// Local memory side widths
`define AG_ADDR_W 10
`define AG_PERIOD_W 10
`define AG_DELAY_W 7

// Byte offset of one 32-bit data word
`define AG_OFFSET_W 2

`endif

/* hdl/addr_gen_pkg.sv */
`include "addr_gen_consts.svh"

package addr_gen_pkg;

   // One level of the nested loop, period/increment then iteration/shift
   typedef struct packed {
      logic        [`AG_PERIOD_W-1:0] period;
      logic signed [`AG_ADDR_W-1:0]   incr;
      logic        [`AG_ADDR_W-1:0]   iter;
      logic signed [`AG_ADDR_W-1:0]   shift;
   } loop_level_t;

   typedef struct packed {
      logic [`AG_ADDR_W-1:0]   start;
      logic [`AG_PERIOD_W-1:0] duty;
      logic [`AG_DELAY_W-1:0]  delay;
      logic                    ignore_first;
      loop_level_t             level1;
      loop_level_t             level2;
      loop_level_t             level3;
   } addr_cfg_t;

   typedef struct packed {
      logic [`AG_COUNT_W-1:0]    count;
      logic [`AG_AXI_ADDR_W-1:0] start_addr;
      logic [`AG_AXI_ADDR_W-1:0] addr_shift;
      logic [`AG_LEN_W-1:0]      len;
      logic                      reading;
   } bus_cfg_t;

   typedef struct packed {
      logic [`AG_ADDR_W-1:0] addr;
      logic                  store;
   } addr_beat_t;

   typedef struct packed {
      logic [`AG_AXI_ADDR_W-1:0] addr;
      logic [`AG_LEN_W-1:0]      len;
   } bus_req_t;

   // Which counter wraps on an accepted beat, innermost first
   typedef enum logic [2:0] {
      STEP_PER,
      END_PER,
      END_ITER1,
      END_PER2,
      END_ITER2,
      END_PER3,
      FINISH
   } loop_step_e;

   typedef enum logic [1:0] {
      BUS_IDLE,
      BUS_NEXT,
      BUS_XFER
   } bus_state_e;

endpackage

/* hdl/loop_nest_addr.sv */
`timescale 1ns/1ps
`include "addr_gen_consts.svh"

module loop_nest_addr (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     run_i,
   input  addr_gen_pkg::addr_cfg_t  cfg_i,
   input  logic                     beat_ready_i,
   output logic                     beat_valid_o,
   output addr_gen_pkg::addr_beat_t beat_o,
   output logic                     done_o
);

   addr_gen_pkg::addr_cfg_t  cfg_q;
   addr_gen_pkg::loop_step_e step;

   logic [`AG_DELAY_W-1:0]  delay_q;
   logic [`AG_ADDR_W-1:0]   addr_q;
   logic [`AG_ADDR_W-1:0]   base2_q;
   logic [`AG_ADDR_W-1:0]   base3_q;
   logic [`AG_PERIOD_W-1:0] per1_q;
   logic [`AG_PERIOD_W-1:0] per2_q;
   logic [`AG_PERIOD_W-1:0] per3_q;
   logic [`AG_ADDR_W-1:0]   iter1_q;
   logic [`AG_ADDR_W-1:0]   iter2_q;
   logic [`AG_ADDR_W-1:0]   iter3_q;
   logic                    ignore_q;
   logic                    valid_q;
   logic                    done_q;

   logic per1_end;
   logic iter1_end;
   logic per2_end;
   logic iter2_end;
   logic per3_end;
   logic iter3_end;
   logic in_duty;

   logic [`AG_ADDR_W-1:0] start_addr;
   logic [`AG_ADDR_W-1:0] base2_incr;
   logic [`AG_ADDR_W-1:0] base2_shift;
   logic [`AG_ADDR_W-1:0] base3_incr;
   logic [`AG_ADDR_W-1:0] base3_shift;

   // Word index to byte address, wrapping at the local address width
   function automatic logic [`AG_ADDR_W-1:0] word_off(input logic [`AG_ADDR_W-1:0] val);
      return val << `AG_OFFSET_W;
   endfunction

   // A zero period or iteration count behaves like a count of one
   assign per1_end  = (cfg_q.level1.period == '0) || (per1_q + 1'b1 == cfg_q.level1.period);
   assign iter1_end = (cfg_q.level1.iter == '0) || (iter1_q + 1'b1 == cfg_q.level1.iter);
   assign per2_end  = (cfg_q.level2.period == '0) || (per2_q + 1'b1 == cfg_q.level2.period);
   assign iter2_end = (cfg_q.level2.iter == '0) || (iter2_q + 1'b1 == cfg_q.level2.iter);
   assign per3_end  = (cfg_q.level3.period == '0) || (per3_q + 1'b1 == cfg_q.level3.period);
   assign iter3_end = (cfg_q.level3.iter == '0) || (iter3_q + 1'b1 == cfg_q.level3.iter);

   always_comb begin
      if (!per1_end) begin
         step = addr_gen_pkg::STEP_PER;
      end else if (!iter1_end) begin
         step = addr_gen_pkg::END_PER;
      end else if (!per2_end) begin
         step = addr_gen_pkg::END_ITER1;
      end else if (!iter2_end) begin
         step = addr_gen_pkg::END_PER2;
      end else if (!per3_end) begin
         step = addr_gen_pkg::END_ITER2;
      end else if (!iter3_end) begin
         step = addr_gen_pkg::END_PER3;
      end else begin
         step = addr_gen_pkg::FINISH;
      end
   end

   assign in_duty     = (per1_q < cfg_q.duty);
   assign start_addr  = word_off(cfg_i.start);
   assign base2_incr  = base2_q + word_off(cfg_q.level2.incr);
   assign base2_shift = base2_q + word_off(cfg_q.level2.shift);
   assign base3_incr  = base3_q + word_off(cfg_q.level3.incr);
   assign base3_shift = base3_q + word_off(cfg_q.level3.shift);

   always_ff @(posedge clk_i) begin
      if (run_i) begin
         cfg_q <= cfg_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_q  <= '0;
         addr_q   <= '0;
         base2_q  <= '0;
         base3_q  <= '0;
         per1_q   <= '0;
         per2_q   <= '0;
         per3_q   <= '0;
         iter1_q  <= '0;
         iter2_q  <= '0;
         iter3_q  <= '0;
         ignore_q <= 1'b0;
         valid_q  <= 1'b0;
         done_q   <= 1'b1;
      end else if (run_i) begin
         delay_q  <= cfg_i.delay;
         addr_q   <= start_addr;
         base2_q  <= start_addr;
         base3_q  <= start_addr;
         per1_q   <= '0;
         per2_q   <= '0;
         per3_q   <= '0;
         iter1_q  <= '0;
         iter2_q  <= '0;
         iter3_q  <= '0;
         ignore_q <= cfg_i.ignore_first;
         valid_q  <= (cfg_i.delay == '0);
         done_q   <= 1'b0;
      end else if (delay_q != '0) begin
         // Valid rises together with the last delay count
         delay_q <= delay_q - 1'b1;
         valid_q <= (delay_q == 'd1);
      end else if (valid_q && beat_ready_i) begin
         case (step)
            addr_gen_pkg::STEP_PER: begin
               if (in_duty && !ignore_q) begin
                  addr_q <= addr_q + word_off(cfg_q.level1.incr);
               end
               per1_q <= per1_q + 1'b1;
            end
            addr_gen_pkg::END_PER: begin
               if (!ignore_q) begin
                  addr_q <= addr_q + word_off(cfg_q.level1.shift);
               end
               per1_q   <= '0;
               iter1_q  <= iter1_q + 1'b1;
               ignore_q <= 1'b0;
            end
            addr_gen_pkg::END_ITER1: begin
               if (!ignore_q) begin
                  addr_q  <= base2_incr;
                  base2_q <= base2_incr;
               end
               per1_q   <= '0;
               iter1_q  <= '0;
               per2_q   <= per2_q + 1'b1;
               ignore_q <= 1'b0;
            end
            addr_gen_pkg::END_PER2: begin
               if (!ignore_q) begin
                  addr_q  <= base2_shift;
                  base2_q <= base2_shift;
               end
               per1_q   <= '0;
               iter1_q  <= '0;
               per2_q   <= '0;
               iter2_q  <= iter2_q + 1'b1;
               ignore_q <= 1'b0;
            end
            addr_gen_pkg::END_ITER2: begin
               if (!ignore_q) begin
                  addr_q  <= base3_incr;
                  base2_q <= base3_incr;
                  base3_q <= base3_incr;
               end
               per1_q   <= '0;
               iter1_q  <= '0;
               per2_q   <= '0;
               iter2_q  <= '0;
               per3_q   <= per3_q + 1'b1;
               ignore_q <= 1'b0;
            end
            addr_gen_pkg::END_PER3: begin
               if (!ignore_q) begin
                  addr_q  <= base3_shift;
                  base2_q <= base3_shift;
                  base3_q <= base3_shift;
               end
               per1_q   <= '0;
               iter1_q  <= '0;
               per2_q   <= '0;
               iter2_q  <= '0;
               per3_q   <= '0;
               iter3_q  <= iter3_q + 1'b1;
               ignore_q <= 1'b0;
            end
            default: begin
               // Last beat of the whole nest was accepted
               valid_q <= 1'b0;
               done_q  <= 1'b1;
            end
         endcase
      end
   end

   assign beat_valid_o = valid_q;
   assign beat_o.addr  = addr_q;
   assign beat_o.store = in_duty && !ignore_q;
   assign done_o       = done_q;

endmodule

/* hdl/databus_burst_seq.sv */
`timescale 1ns/1ps
`include "addr_gen_consts.svh"

module databus_burst_seq (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   run_i,
   input  addr_gen_pkg::bus_cfg_t cfg_i,
   input  logic                   bus_ready_i,
   input  logic                   bus_last_i,
   input  logic                   data_ready_i,
   input  logic                   data_valid_i,
   output logic                   bus_valid_o,
   output addr_gen_pkg::bus_req_t bus_req_o,
   output logic                   data_last_o,
   output logic                   done_o
);

   addr_gen_pkg::bus_cfg_t   cfg_q;
   addr_gen_pkg::bus_state_e state_q;

   logic [`AG_AXI_ADDR_W-1:0] addr_q;
   logic [`AG_COUNT_W-1:0]    remain_q;
   logic                      valid_q;
   logic                      start_ok;
   logic                      burst_done;

   // A run with nothing to move leaves the sequencer idle
   assign start_ok = run_i && (cfg_i.count != '0) && (cfg_i.len != '0);

   always_ff @(posedge clk_i) begin
      if (run_i && (state_q == addr_gen_pkg::BUS_IDLE)) begin
         cfg_q <= cfg_i;
      end
   end

   // Reads wait for room in the data path, writes wait for data to send
   assign bus_valid_o = (state_q == addr_gen_pkg::BUS_XFER) &&
                        (cfg_q.reading ? (valid_q && data_ready_i) : data_valid_i);

   assign burst_done = bus_valid_o && bus_ready_i && bus_last_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q  <= addr_gen_pkg::BUS_IDLE;
         addr_q   <= '0;
         remain_q <= '0;
         valid_q  <= 1'b0;
      end else begin
         case (state_q)
            addr_gen_pkg::BUS_IDLE: begin
               if (start_ok) begin
                  state_q  <= addr_gen_pkg::BUS_NEXT;
                  addr_q   <= cfg_i.start_addr;
                  remain_q <= cfg_i.count;
               end
            end
            addr_gen_pkg::BUS_NEXT: begin
               if (remain_q == '0) begin
                  state_q <= addr_gen_pkg::BUS_IDLE;
               end else begin
                  state_q <= addr_gen_pkg::BUS_XFER;
                  valid_q <= 1'b1;
               end
            end
            addr_gen_pkg::BUS_XFER: begin
               if (burst_done) begin
                  state_q  <= addr_gen_pkg::BUS_NEXT;
                  valid_q  <= 1'b0;
                  addr_q   <= addr_q + cfg_q.addr_shift;
                  remain_q <= remain_q - 1'b1;
               end
            end
            default: begin
               state_q <= addr_gen_pkg::BUS_IDLE;
            end
         endcase
      end
   end

   assign bus_req_o.addr = addr_q;
   assign bus_req_o.len  = cfg_q.len;

   // Only one burst left means this burst end closes the transfer
   assign data_last_o = burst_done && (remain_q == 'd1);
   assign done_o      = (state_q == addr_gen_pkg::BUS_IDLE);

endmodule

/* hdl/addr_gen_top.sv */
`timescale 1ns/1ps

module addr_gen_top (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     run_i,
   input  addr_gen_pkg::addr_cfg_t  addr_cfg_i,
   input  addr_gen_pkg::bus_cfg_t   bus_cfg_i,
   input  logic                     beat_ready_i,
   input  logic                     bus_ready_i,
   input  logic                     bus_last_i,
   input  logic                     data_ready_i,
   input  logic                     data_valid_i,
   output logic                     beat_valid_o,
   output addr_gen_pkg::addr_beat_t beat_o,
   output logic                     bus_valid_o,
   output addr_gen_pkg::bus_req_t   bus_req_o,
   output logic                     data_last_o,
   output logic                     done_o
);

   logic addr_done;
   logic bus_done;

   // Both engines start on the same run pulse and then run independently
   loop_nest_addr u_loop_nest_addr (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .run_i        (run_i),
      .cfg_i        (addr_cfg_i),
      .beat_ready_i (beat_ready_i),
      .beat_valid_o (beat_valid_o),
      .beat_o       (beat_o),
      .done_o       (addr_done)
   );

   databus_burst_seq u_databus_burst_seq (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .run_i        (run_i),
      .cfg_i        (bus_cfg_i),
      .bus_ready_i  (bus_ready_i),
      .bus_last_i   (bus_last_i),
      .data_ready_i (data_ready_i),
      .data_valid_i (data_valid_i),
      .bus_valid_o  (bus_valid_o),
      .bus_req_o    (bus_req_o),
      .data_last_o  (data_last_o),
      .done_o       (bus_done)
   );

   assign done_o = addr_done && bus_done;

endmodule

/* verif/addr_gen_assert.sv */
`timescale 1ns/1ps

module addr_gen_assert (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     beat_valid_i,
   input logic                     beat_ready_i,
   input addr_gen_pkg::addr_beat_t beat_i,
   input logic                     bus_valid_i,
   input logic                     bus_ready_i,
   input addr_gen_pkg::bus_req_t   bus_req_i,
   input logic                     done_i
);

   // A stalled beat must keep its address and store flag
   beat_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      beat_valid_i && !beat_ready_i |=> $stable(beat_i))
      else $error("beat_o changed while stalled");

   bus_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      bus_valid_i && !bus_ready_i |=> $stable(bus_req_i))
      else $error("bus_req_o changed while stalled");

   idle_when_done: assert property (@(posedge clk_i) disable iff (rst_i)
      done_i |-> !beat_valid_i && !bus_valid_i)
      else $error("valid high while done_o is high");

   quiet_after_reset: assert property (@(posedge clk_i)
      $fell(rst_i) |-> !beat_valid_i && !bus_valid_i)
      else $error("valid high right after reset");

endmodule

bind addr_gen_top addr_gen_assert u_assert (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .beat_valid_i (beat_valid_o),
   .beat_ready_i (beat_ready_i),
   .beat_i       (beat_o),
   .bus_valid_i  (bus_valid_o),
   .bus_ready_i  (bus_ready_i),
   .bus_req_i    (bus_req_o),
   .done_i       (done_o)
);

/* verif/addr_gen_checker.sv */
`timescale 1ns/1ps
`include "addr_gen_consts.svh"

module addr_gen_checker (
   input logic                     clk_i,
   input logic                     rst_i,
   input logic                     beat_valid_i,
   input logic                     beat_ready_i,
   input addr_gen_pkg::addr_beat_t beat_i,
   input logic                     bus_valid_i,
   input logic                     bus_ready_i,
   input logic                     bus_last_i,
   input addr_gen_pkg::bus_req_t   bus_req_i,
   input logic                     data_last_i
);

   int pass_cnt = 0;
   int fail_cnt = 0;
   int errors;

   logic [31:0]               beats;
   logic [31:0]               stores;
   logic [15:0]               addr_sum;
   logic [`AG_ADDR_W-1:0]     last_addr;
   logic [31:0]               bursts;
   logic [`AG_AXI_ADDR_W-1:0] final_addr;
   logic [`AG_LEN_W-1:0]      final_len;
   logic [31:0]               last_pulses;

   // Start a fresh accumulation before each run
   task automatic clear_results();
      beats       = '0;
      stores      = '0;
      addr_sum    = '0;
      last_addr   = '0;
      bursts      = '0;
      final_addr  = '0;
      final_len   = '0;
      last_pulses = '0;
   endtask

   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (beat_valid_i && beat_ready_i) begin
            beats     = beats + 1;
            last_addr = beat_i.addr;
            if (beat_i.store) begin
               stores   = stores + 1;
               addr_sum = addr_sum + 16'(beat_i.addr);
            end
         end
         if (bus_valid_i && bus_ready_i && bus_last_i) begin
            bursts     = bursts + 1;
            final_addr = bus_req_i.addr;
            final_len  = bus_req_i.len;
         end
         if (data_last_i) begin
            last_pulses = last_pulses + 1;
         end
      end
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic check_test(input int idx, input logic [31:0] exp_beats,
                             input logic [31:0] exp_stores, input logic [31:0] exp_sum,
                             input logic [31:0] exp_last, input logic [31:0] exp_bursts,
                             input logic [31:0] exp_final, input logic [31:0] exp_len);
      errors = 0;
      compare("beat count", beats, exp_beats);
      compare("store count", stores, exp_stores);
      compare("store address sum", 32'(addr_sum), exp_sum & 32'hffff);
      compare("beat_o.addr (last)", 32'(last_addr), exp_last);
      compare("burst count", bursts, exp_bursts);
      compare("bus_req_o.addr (final)", final_addr, exp_final);
      compare("bus_req_o.len (final)", 32'(final_len), (exp_bursts != 0) ? exp_len : 32'd0);
      compare("data_last_o pulses", last_pulses, (exp_bursts != 0) ? 32'd1 : 32'd0);
      if (errors == 0) begin
         $display("Test %0d passed", idx);
         pass_cnt = pass_cnt + 1;
      end else begin
         $display("Test %0d failed with %0d mismatches", idx, errors);
         fail_cnt = fail_cnt + 1;
      end
   endtask

endmodule

/* verif/addr_gen_tb.sv */
`timescale 1ns/1ps
`include "addr_gen_consts.svh"

module addr_gen_tb;

   localparam int NUM_TESTS      = 5;
   localparam int FIELDS         = 27;
   localparam int TIMEOUT_CYCLES = 2000;

   logic                     clk_i;
   logic                     rst_i;
   logic                     run_i;
   addr_gen_pkg::addr_cfg_t  addr_cfg_i;
   addr_gen_pkg::bus_cfg_t   bus_cfg_i;
   logic                     beat_ready_i;
   logic                     bus_ready_i;
   logic                     bus_last_i;
   logic                     data_ready_i;
   logic                     data_valid_i;
   logic                     beat_valid_o;
   addr_gen_pkg::addr_beat_t beat_o;
   logic                     bus_valid_o;
   addr_gen_pkg::bus_req_t   bus_req_o;
   logic                     data_last_o;
   logic                     done_o;

   logic [31:0]           tests_mem [0:NUM_TESTS*FIELDS-1];
   logic [`AG_LEN_W-1:0]  cur_len;
   logic [31:0]           rnd;
   integer                seed;
   integer                beat_cnt;
   int                    timeouts;

   addr_gen_top DUT (.*);

   addr_gen_checker u_checker (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .beat_valid_i (beat_valid_o),
      .beat_ready_i (beat_ready_i),
      .beat_i       (beat_o),
      .bus_valid_i  (bus_valid_o),
      .bus_ready_i  (bus_ready_i),
      .bus_last_i   (bus_last_i),
      .bus_req_i    (bus_req_o),
      .data_last_i  (data_last_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // Bus responder counts accepted beats and marks every len-th one as last
   always @(posedge clk_i) begin
      if (bus_valid_o && bus_ready_i) begin
         beat_cnt = bus_last_i ? 0 : beat_cnt + 1;
      end
   end

   // Random back-pressure on both ready inputs
   always @(negedge clk_i) begin
      if (!rst_i) begin
         rnd          = $random(seed);
         beat_ready_i = rnd[0];
         bus_ready_i  = rnd[1];
         bus_last_i   = (beat_cnt == int'(cur_len) - 1);
      end
   end

   function automatic addr_gen_pkg::loop_level_t level_from(input int base);
      addr_gen_pkg::loop_level_t lvl;
      lvl.period = tests_mem[base][`AG_PERIOD_W-1:0];
      lvl.incr   = tests_mem[base+1][`AG_ADDR_W-1:0];
      lvl.iter   = tests_mem[base+2][`AG_ADDR_W-1:0];
      lvl.shift  = tests_mem[base+3][`AG_ADDR_W-1:0];
      return lvl;
   endfunction

   task automatic run_test(input int idx);
      int b;
      int cycles;
      b = idx * FIELDS;
      @(negedge clk_i);
      addr_cfg_i.start        = tests_mem[b][`AG_ADDR_W-1:0];
      addr_cfg_i.duty         = tests_mem[b+1][`AG_PERIOD_W-1:0];
      addr_cfg_i.delay        = tests_mem[b+2][`AG_DELAY_W-1:0];
      addr_cfg_i.ignore_first = tests_mem[b+3][0];
      addr_cfg_i.level1       = level_from(b + 4);
      addr_cfg_i.level2       = level_from(b + 8);
      addr_cfg_i.level3       = level_from(b + 12);
      bus_cfg_i.count         = tests_mem[b+16][`AG_COUNT_W-1:0];
      bus_cfg_i.start_addr    = tests_mem[b+17];
      bus_cfg_i.addr_shift    = tests_mem[b+18];
      bus_cfg_i.len           = tests_mem[b+19][`AG_LEN_W-1:0];
      bus_cfg_i.reading       = tests_mem[b+20][0];
      cur_len                 = bus_cfg_i.len;
      beat_cnt                = 0;
      u_checker.clear_results();
      run_i = 1'b1;
      @(negedge clk_i);
      run_i  = 1'b0;
      cycles = 0;
      while (!done_o && cycles < TIMEOUT_CYCLES) begin
         @(negedge clk_i);
         cycles = cycles + 1;
      end
      if (!done_o) begin
         $display("Test %0d timed out waiting for done_o to return high", idx);
         timeouts = timeouts + 1;
      end else begin
         u_checker.check_test(idx, tests_mem[b+21], tests_mem[b+22], tests_mem[b+23],
                              tests_mem[b+24], tests_mem[b+25], tests_mem[b+26],
                              tests_mem[b+19]);
      end
   endtask

   initial begin
      seed         = 32;
      beat_cnt     = 0;
      timeouts     = 0;
      cur_len      = '0;
      rst_i        = 1'b1;
      run_i        = 1'b0;
      addr_cfg_i   = '0;
      bus_cfg_i    = '0;
      beat_ready_i = 1'b0;
      bus_ready_i  = 1'b0;
      bus_last_i   = 1'b0;
      data_ready_i = 1'b1;
      data_valid_i = 1'b1;
      $readmemh("verif/addr_gen_tests.txt", tests_mem);
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(i);
      end
      $display("Tests passed: %0d, failed: %0d, timed out: %0d",
               u_checker.pass_cnt, u_checker.fail_cnt, timeouts);
      if (u_checker.fail_cnt == 0 && timeouts == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+hdl
hdl/addr_gen_pkg.sv
hdl/loop_nest_addr.sv
hdl/databus_burst_seq.sv
hdl/addr_gen_top.sv
verif/addr_gen_assert.sv
verif/addr_gen_checker.sv
verif/addr_gen_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= addr_gen_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/addr_gen_tests.txt */
// start duty delay ignore | L1 per incr iter shift | L2 ... | L3 ... | count bstart bshift len rd
// expected: beats stores sum last bursts final_burst_addr
4 3 0 0 5 1 0 0 0 0 0 0 0 0 0 0 2 1000 100 4 1 5 3 3C 1C 2 1100
40 2 0 0 2 1 2 3FF 2 10 0 0 0 0 2 3E0 3 2000 FFFFFFF0 2 0 10 10 E20 C4 3 1FE0
0 2 3 1 3 2 2 5 0 0 0 0 0 0 0 0 1 3000 40 3 1 6 2 8 10 1 3000
8 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 4 100 80 1 0 1 0 0 20 4 280
1 4 0 0 4 3 0 0 0 0 0 0 0 0 0 0 0 500 4 4 1 4 4 58 28 0 0
